// File: common/pmu_pkg.sv
package pmu_pkg;

  localparam int unsigned NumCounters = 6;
  localparam int unsigned FifoDepth   = 4;  // Also the producer's initial credit count
  localparam int unsigned CsrAddrW    = 8;

  // Register map offsets
  localparam logic [CsrAddrW-1:0] CntLoBase   = 8'h00;
  localparam logic [CsrAddrW-1:0] CntHiBase   = 8'h08;
  localparam logic [CsrAddrW-1:0] EvtCfgBase  = 8'h10;
  localparam logic [CsrAddrW-1:0] InhibitAddr = 8'h18;
  localparam logic [CsrAddrW-1:0] OvfStatAddr = 8'h19;

  typedef enum logic [2:0] {
    FU_ALU    = 3'd0,
    FU_MUL    = 3'd1,
    FU_LOAD   = 3'd2,
    FU_STORE  = 3'd3,
    FU_BRANCH = 3'd4,
    FU_JUMP   = 3'd5,
    FU_FPU    = 3'd6
  } fu_class_e;

  // One retired instruction from the commit stage
  typedef struct packed {
    fu_class_e  fu;
    logic [4:0] rd;
    logic       is_jalr;
    logic       mispredict;  // Only meaningful for branches
  } commit_rec_t;

  typedef struct packed {
    logic icache_miss;
    logic dcache_miss;
    logic itlb_miss;
    logic dtlb_miss;
    logic exception;
    logic stall;
  } hw_events_t;

  typedef enum logic [4:0] {
    EVT_NONE        = 5'd0,
    EVT_ICACHE_MISS = 5'd1,
    EVT_DCACHE_MISS = 5'd2,
    EVT_ITLB_MISS   = 5'd3,
    EVT_DTLB_MISS   = 5'd4,
    EVT_LOAD        = 5'd5,
    EVT_STORE       = 5'd6,
    EVT_EXCEPTION   = 5'd7,
    EVT_BRANCH      = 5'd8,
    EVT_MISPREDICT  = 5'd9,
    EVT_CALL        = 5'd10,
    EVT_RETURN      = 5'd11,
    EVT_INTEGER     = 5'd12,
    EVT_FP          = 5'd13,
    EVT_STALL       = 5'd14
  } evt_sel_e;

  typedef struct packed {
    logic [25:0] reserved;  // Reads as zero
    logic        ovf_irq_en;
    evt_sel_e    sel;
  } evt_cfg_t;

  // Register-port data word seen as a counter half or as a config word
  typedef union packed {
    logic [31:0] raw;
    evt_cfg_t    cfg;
  } csr_word_u;

  typedef struct packed {
    logic                valid;
    logic                we;
    logic [CsrAddrW-1:0] addr;
    csr_word_u           wdata;
  } csr_req_t;

  typedef struct packed {
    logic        valid;
    logic        err;
    logic [31:0] rdata;
  } csr_rsp_t;

  // Software write into one counter half
  typedef struct packed {
    logic [NumCounters-1:0] sel;  // One-hot counter index
    logic                   hi;
    logic [31:0]            data;
  } cnt_wr_t;

endpackage

// File: source/commit_fifo.sv
`timescale 1ns/1ps

module commit_fifo (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                commit_valid_i,
  input  pmu_pkg::commit_rec_t commit_rec_i,
  output logic                pop_valid_o,
  output pmu_pkg::commit_rec_t pop_rec_o,
  output logic                credit_o
);

  import pmu_pkg::*;

  commit_rec_t                     mem_q [FifoDepth];
  logic [$clog2(FifoDepth)-1:0]    wr_ptr_q;
  logic [$clog2(FifoDepth)-1:0]    rd_ptr_q;
  logic [$clog2(FifoDepth+1)-1:0]  fill_q;
  logic                            pop;

  // Drain one entry per cycle whenever something is stored
  assign pop         = (fill_q != '0);
  assign pop_valid_o = pop;
  assign pop_rec_o   = mem_q[rd_ptr_q];
  assign credit_o    = pop;  // Each pop hands one credit back

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (commit_valid_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({commit_valid_i, pop})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (commit_valid_i) mem_q[wr_ptr_q] <= commit_rec_i;
  end

  // Producer must hold a credit, so a full FIFO never sees a beat
  a_no_write_when_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_valid_i |-> (fill_q != FifoDepth))
    else $error("commit_fifo: beat sent without credit");

  a_fill_bounded : assert property (@(posedge clk_i) disable iff (!rst_ni)
    fill_q <= FifoDepth);

endmodule

// File: perf_counters/event_decoder.sv
`timescale 1ns/1ps

module event_decoder (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       pop_valid_i,
  input  pmu_pkg::commit_rec_t                       pop_rec_i,
  input  pmu_pkg::hw_events_t                        hw_events_i,
  input  pmu_pkg::evt_cfg_t [pmu_pkg::NumCounters-1:0] evt_cfg_i,
  output logic [pmu_pkg::NumCounters-1:0]            evt_hit_o
);

  import pmu_pkg::*;

  logic is_load;
  logic is_store;
  logic is_branch;
  logic is_mispredict;
  logic is_call;
  logic is_return;
  logic is_integer;
  logic is_fp;

  logic [NumCounters-1:0] hit_d;
  logic [NumCounters-1:0] hit_q;

  // Classify the record popped this cycle
  always_comb begin
    is_load       = pop_valid_i && (pop_rec_i.fu == FU_LOAD);
    is_store      = pop_valid_i && (pop_rec_i.fu == FU_STORE);
    is_branch     = pop_valid_i && (pop_rec_i.fu == FU_BRANCH);
    is_mispredict = is_branch && pop_rec_i.mispredict;
    // Link register x1 or x5 marks a call
    is_call       = pop_valid_i && (pop_rec_i.fu == FU_JUMP) &&
                    ((pop_rec_i.rd == 5'd1) || (pop_rec_i.rd == 5'd5));
    is_return     = pop_valid_i && pop_rec_i.is_jalr && (pop_rec_i.rd == 5'd0);
    is_integer    = pop_valid_i && ((pop_rec_i.fu == FU_ALU) || (pop_rec_i.fu == FU_MUL));
    is_fp         = pop_valid_i && (pop_rec_i.fu == FU_FPU);
  end

  // Per-counter event mux
  always_comb begin
    hit_d = '0;
    for (int i = 0; i < NumCounters; i++) begin
      case (evt_cfg_i[i].sel)
        EVT_ICACHE_MISS: hit_d[i] = hw_events_i.icache_miss;
        EVT_DCACHE_MISS: hit_d[i] = hw_events_i.dcache_miss;
        EVT_ITLB_MISS:   hit_d[i] = hw_events_i.itlb_miss;
        EVT_DTLB_MISS:   hit_d[i] = hw_events_i.dtlb_miss;
        EVT_LOAD:        hit_d[i] = is_load;
        EVT_STORE:       hit_d[i] = is_store;
        EVT_EXCEPTION:   hit_d[i] = hw_events_i.exception;
        EVT_BRANCH:      hit_d[i] = is_branch;
        EVT_MISPREDICT:  hit_d[i] = is_mispredict;
        EVT_CALL:        hit_d[i] = is_call;
        EVT_RETURN:      hit_d[i] = is_return;
        EVT_INTEGER:     hit_d[i] = is_integer;
        EVT_FP:          hit_d[i] = is_fp;
        EVT_STALL:       hit_d[i] = hw_events_i.stall;
        default:         hit_d[i] = 1'b0;  // EVT_NONE and unused codes
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hit_q <= '0;
    end else begin
      hit_q <= hit_d;
    end
  end

  assign evt_hit_o = hit_q;

endmodule

// File: perf_counters/hpm_counter_bank.sv
`timescale 1ns/1ps

module hpm_counter_bank (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic [pmu_pkg::NumCounters-1:0]          evt_hit_i,
  input  logic                                     count_en_i,
  input  logic [pmu_pkg::NumCounters-1:0]          inhibit_i,
  input  pmu_pkg::cnt_wr_t                         cnt_wr_i,
  output logic [pmu_pkg::NumCounters-1:0][63:0]    cnt_o,
  output logic [pmu_pkg::NumCounters-1:0]          wrap_o
);

  import pmu_pkg::*;

  logic [NumCounters-1:0][63:0] cnt_q;
  logic [NumCounters-1:0]       inc;
  logic [NumCounters-1:0]       wrap_q;

  // Global enable from the FSM, then the per-counter inhibit
  assign inc = evt_hit_i & ~inhibit_i & {NumCounters{count_en_i}};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q  <= '0;
      wrap_q <= '0;
    end else begin
      for (int i = 0; i < NumCounters; i++) begin
        // Software write beats the increment
        if (cnt_wr_i.sel[i]) begin
          if (cnt_wr_i.hi) begin
            cnt_q[i][63:32] <= cnt_wr_i.data;
          end else begin
            cnt_q[i][31:0] <= cnt_wr_i.data;
          end
        end else if (inc[i]) begin
          cnt_q[i] <= cnt_q[i] + 64'd1;
        end
        wrap_q[i] <= inc[i] && !cnt_wr_i.sel[i] && (&cnt_q[i]);  // All ones rolling over
      end
    end
  end

  assign cnt_o  = cnt_q;
  assign wrap_o = wrap_q;

  for (genvar g = 0; g < NumCounters; g++) begin : g_wrap_chk
    a_wrap_to_zero : assert property (@(posedge clk_i) disable iff (!rst_ni)
      wrap_q[g] |-> (cnt_q[g] == '0));
  end

endmodule

// File: perf_counters/count_ctrl_fsm.sv
`timescale 1ns/1ps

module count_ctrl_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_i,
  input  logic ovf_pending_i,
  output logic count_en_o,
  output logic irq_o
);

  typedef enum logic [1:0] {
    RUN        = 2'd0,
    HALT_DEBUG = 2'd1,
    HALT_OVF   = 2'd2
  } ctrl_state_e;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      RUN: begin
        if (ovf_pending_i) begin
          state_d = HALT_OVF;  // Overflow outranks debug
        end else if (debug_i) begin
          state_d = HALT_DEBUG;
        end
      end
      HALT_DEBUG: begin
        if (ovf_pending_i) begin
          state_d = HALT_OVF;
        end else if (!debug_i) begin
          state_d = RUN;
        end
      end
      HALT_OVF: begin
        // Stay frozen until software clears the status
        if (!ovf_pending_i) state_d = RUN;
      end
      default: state_d = RUN;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RUN;
    end else begin
      state_q <= state_d;
    end
  end

  assign count_en_o = (state_q == RUN);
  assign irq_o      = (state_q == HALT_OVF);

endmodule

// File: source/pmu_csr_regs.sv
`timescale 1ns/1ps

module pmu_csr_regs (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  pmu_pkg::csr_req_t                           csr_req_i,
  output pmu_pkg::csr_rsp_t                           csr_rsp_o,
  input  logic [pmu_pkg::NumCounters-1:0][63:0]       cnt_i,
  input  logic [pmu_pkg::NumCounters-1:0]             wrap_i,
  output pmu_pkg::evt_cfg_t [pmu_pkg::NumCounters-1:0] evt_cfg_o,
  output logic [pmu_pkg::NumCounters-1:0]             inhibit_o,
  output pmu_pkg::cnt_wr_t                            cnt_wr_o,
  output logic                                        ovf_pending_o
);

  import pmu_pkg::*;

  evt_cfg_t [NumCounters-1:0] evt_cfg_q;
  logic [NumCounters-1:0]     inhibit_q;
  logic [NumCounters-1:0]     ovf_q;
  logic [NumCounters-1:0]     irq_en;

  logic [2:0]  idx;
  logic        in_range;
  logic        sel_lo;
  logic        sel_hi;
  logic        sel_cfg;
  logic        sel_inh;
  logic        sel_ovf;
  logic        mapped;
  logic        wr_en;
  csr_word_u   rd_word;

  logic        rsp_valid_q;
  logic        rsp_err_q;
  logic [31:0] rdata_q;

  // Banks of eight with six live slots each
  assign idx      = csr_req_i.addr[2:0];
  assign in_range = (idx < 3'(NumCounters));
  assign sel_lo   = (csr_req_i.addr[7:3] == CntLoBase[7:3]) && in_range;
  assign sel_hi   = (csr_req_i.addr[7:3] == CntHiBase[7:3]) && in_range;
  assign sel_cfg  = (csr_req_i.addr[7:3] == EvtCfgBase[7:3]) && in_range;
  assign sel_inh  = (csr_req_i.addr == InhibitAddr);
  assign sel_ovf  = (csr_req_i.addr == OvfStatAddr);
  assign mapped   = sel_lo | sel_hi | sel_cfg | sel_inh | sel_ovf;
  assign wr_en    = csr_req_i.valid && csr_req_i.we && mapped;

  // Counter half writes go straight to the bank
  always_comb begin
    cnt_wr_o      = '0;
    cnt_wr_o.hi   = sel_hi;
    cnt_wr_o.data = csr_req_i.wdata.raw;
    if (wr_en && (sel_lo || sel_hi)) cnt_wr_o.sel[idx] = 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      evt_cfg_q <= '0;
      inhibit_q <= '0;
      ovf_q     <= '0;
    end else begin
      if (wr_en && sel_cfg) begin
        evt_cfg_q[idx]            <= '0;  // Reserved bits stay zero
        evt_cfg_q[idx].ovf_irq_en <= csr_req_i.wdata.cfg.ovf_irq_en;
        evt_cfg_q[idx].sel        <= csr_req_i.wdata.cfg.sel;
      end
      if (wr_en && sel_inh) inhibit_q <= csr_req_i.wdata.raw[NumCounters-1:0];
      // Writing one clears a bit unless a new wrap sets it again
      if (wr_en && sel_ovf) begin
        ovf_q <= (ovf_q & ~csr_req_i.wdata.raw[NumCounters-1:0]) | wrap_i;
      end else begin
        ovf_q <= ovf_q | wrap_i;
      end
    end
  end

  // Read mux
  always_comb begin
    rd_word = '0;
    if (sel_lo) begin
      rd_word.raw = cnt_i[idx][31:0];
    end else if (sel_hi) begin
      rd_word.raw = cnt_i[idx][63:32];
    end else if (sel_cfg) begin
      rd_word.cfg = evt_cfg_q[idx];
    end else if (sel_inh) begin
      rd_word.raw = 32'(inhibit_q);
    end else if (sel_ovf) begin
      rd_word.raw = 32'(ovf_q);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
      rsp_err_q   <= 1'b0;
    end else begin
      rsp_valid_q <= csr_req_i.valid;
      rsp_err_q   <= csr_req_i.valid && !mapped;
    end
  end

  // Writes and errors answer with zero
  always_ff @(posedge clk_i) begin
    rdata_q <= (csr_req_i.valid && !csr_req_i.we && mapped) ? rd_word.raw : 32'd0;
  end

  always_comb begin
    for (int i = 0; i < NumCounters; i++) begin
      irq_en[i] = evt_cfg_q[i].ovf_irq_en;
    end
  end

  assign ovf_pending_o = |(ovf_q & irq_en);
  assign evt_cfg_o     = evt_cfg_q;
  assign inhibit_o     = inhibit_q;
  assign csr_rsp_o     = '{valid: rsp_valid_q, err: rsp_err_q, rdata: rdata_q};

endmodule

// File: source/pmu_top.sv
`timescale 1ns/1ps

module pmu_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 commit_valid_i,
  input  pmu_pkg::commit_rec_t commit_rec_i,
  output logic                 credit_o,
  input  pmu_pkg::hw_events_t  hw_events_i,
  input  logic                 debug_i,
  input  pmu_pkg::csr_req_t    csr_req_i,
  output pmu_pkg::csr_rsp_t    csr_rsp_o,
  output logic                 irq_o
);

  import pmu_pkg::*;

  logic                         pop_valid;
  commit_rec_t                  pop_rec;
  logic [NumCounters-1:0]       evt_hit;
  evt_cfg_t [NumCounters-1:0]   evt_cfg;
  logic [NumCounters-1:0]       inhibit;
  cnt_wr_t                      cnt_wr;
  logic [NumCounters-1:0][63:0] cnt;
  logic [NumCounters-1:0]       wrap;
  logic                         ovf_pending;
  logic                         count_en;

  commit_fifo u_commit_fifo (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .commit_valid_i (commit_valid_i),
    .commit_rec_i   (commit_rec_i),
    .pop_valid_o    (pop_valid),
    .pop_rec_o      (pop_rec),
    .credit_o       (credit_o)
  );

  event_decoder u_event_decoder (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .pop_valid_i (pop_valid),
    .pop_rec_i   (pop_rec),
    .hw_events_i (hw_events_i),
    .evt_cfg_i   (evt_cfg),
    .evt_hit_o   (evt_hit)
  );

  hpm_counter_bank u_counter_bank (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .evt_hit_i  (evt_hit),
    .count_en_i (count_en),
    .inhibit_i  (inhibit),
    .cnt_wr_i   (cnt_wr),
    .cnt_o      (cnt),
    .wrap_o     (wrap)
  );

  count_ctrl_fsm u_count_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .debug_i       (debug_i),
    .ovf_pending_i (ovf_pending),
    .count_en_o    (count_en),
    .irq_o         (irq_o)
  );

  pmu_csr_regs u_csr_regs (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .csr_req_i     (csr_req_i),
    .csr_rsp_o     (csr_rsp_o),
    .cnt_i         (cnt),
    .wrap_i        (wrap),
    .evt_cfg_o     (evt_cfg),
    .inhibit_o     (inhibit),
    .cnt_wr_o      (cnt_wr),
    .ovf_pending_o (ovf_pending)
  );

endmodule

// File: tests/pmu_clk_gen.sv
`timescale 1ns/1ps

module pmu_clk_gen (
  output logic clk_o
);

  localparam time HalfPeriod = 20ns;  // 40 ns period

  initial begin
    clk_o = 1'b0;
    forever #HalfPeriod clk_o = ~clk_o;
  end

endmodule

// File: tests/pmu_tb.sv
`timescale 1ns/1ps

module pmu_tb;

  import pmu_pkg::*;

  localparam int TrafficCycles = 1200;
  localparam int PulseCycles   = 30;
  // Rough test lengths doubled for the run limit
  localparam int TimeoutCycles = 2 * (50 + 80 + (TrafficCycles + 100) + 200
                                      + 4 * PulseCycles + 100);
  localparam logic [7:0] BadAddr [5] = '{8'h06, 8'h0E, 8'h16, 8'h1A, 8'hFF};

  logic        clk;
  logic        rst_n;
  logic        commit_valid;
  commit_rec_t commit_rec;
  logic        credit;
  hw_events_t  hw_events;
  logic        debug;
  csr_req_t    csr_req;
  csr_rsp_t    csr_rsp;
  logic        irq;

  int    credits;
  int    beats_sent;
  int    pulses_seen;
  logic  req_seen;    // Request valid as seen by the last edge
  logic  debug_seen;
  int    cycles = 0;
  int    errors = 0;
  int    errors_at_start = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  string cur_test;

  // Reference model
  logic [63:0]            model [NumCounters];
  logic [4:0]             sel_m [NumCounters];
  logic [NumCounters-1:0] inhibit_m;

  pmu_clk_gen u_clk_gen (.clk_o(clk));

  pmu_top u_dut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .commit_valid_i (commit_valid),
    .commit_rec_i   (commit_rec),
    .credit_o       (credit),
    .hw_events_i    (hw_events),
    .debug_i        (debug),
    .csr_req_i      (csr_req),
    .csr_rsp_o      (csr_rsp),
    .irq_o          (irq)
  );

  // Producer side credit bookkeeping
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits     <= FifoDepth;
      beats_sent  <= 0;
      pulses_seen <= 0;
      req_seen    <= 1'b0;
      debug_seen  <= 1'b0;
    end else begin
      credits     <= credits + int'(credit) - int'(commit_valid);
      beats_sent  <= beats_sent + int'(commit_valid);
      pulses_seen <= pulses_seen + int'(credit);
      req_seen    <= csr_req.valid;
      debug_seen  <= debug;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout after %0d cycles, run stopped", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  // Checked mid-cycle where every value is settled
  a_credit_range : assert property (@(negedge clk) disable iff (!rst_n)
    (credits >= 0) && (credits <= int'(FifoDepth)))
    else begin
      errors++;
      $display("Producer credit count left its range, now %0d", credits);
    end

  a_pulses_bounded : assert property (@(negedge clk) disable iff (!rst_n)
    pulses_seen <= beats_sent)
    else begin
      errors++;
      $display("More credit pulses than beats sent");
    end

  a_rsp_timing : assert property (@(negedge clk) disable iff (!rst_n)
    csr_rsp.valid == req_seen)
    else begin
      errors++;
      $display("Response valid not exactly one cycle after its request");
    end

  a_irq_freezes : assert property (@(negedge clk) disable iff (!rst_n)
    irq |-> !u_dut.count_en)
    else begin
      errors++;
      $display("Counting still enabled while irq is high");
    end

  a_debug_halts : assert property (@(negedge clk) disable iff (!rst_n)
    debug_seen |-> !u_dut.count_en)
    else begin
      errors++;
      $display("Counting not halted one edge after debug request");
    end

  function automatic logic model_hit(logic [4:0] sel, logic beat, commit_rec_t rec,
                                     hw_events_t hw);
    logic hit;
    hit = 1'b0;
    case (sel)
      5'd1:  hit = hw.icache_miss;
      5'd2:  hit = hw.dcache_miss;
      5'd3:  hit = hw.itlb_miss;
      5'd4:  hit = hw.dtlb_miss;
      5'd5:  hit = beat && (rec.fu == FU_LOAD);
      5'd6:  hit = beat && (rec.fu == FU_STORE);
      5'd7:  hit = hw.exception;
      5'd8:  hit = beat && (rec.fu == FU_BRANCH);
      5'd9:  hit = beat && (rec.fu == FU_BRANCH) && rec.mispredict;
      5'd10: hit = beat && (rec.fu == FU_JUMP) && ((rec.rd == 5'd1) || (rec.rd == 5'd5));
      5'd11: hit = beat && rec.is_jalr && (rec.rd == 5'd0);
      5'd12: hit = beat && ((rec.fu == FU_ALU) || (rec.fu == FU_MUL));
      5'd13: hit = beat && (rec.fu == FU_FPU);
      5'd14: hit = hw.stall;
      default: hit = 1'b0;
    endcase
    return hit;
  endfunction

  function automatic commit_rec_t random_rec();
    commit_rec_t rec;
    rec.fu         = fu_class_e'(3'($urandom_range(6, 0)));
    rec.rd         = 5'($urandom_range(7, 0));  // Small range hits x0, x1 and x5 often
    rec.is_jalr    = 1'($urandom);
    rec.mispredict = 1'($urandom);
    return rec;
  endfunction

  task automatic start_test(input string name);
    cur_test        = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != errors_at_start) begin
      tests_failed++;
      $display("test %s: %0d errors", cur_test, errors - errors_at_start);
    end else begin
      $display("test %s: ok", cur_test);
    end
  endtask

  task automatic check_eq(input string what, input logic [63:0] expected,
                          input logic [63:0] actual);
    assert (actual === expected)
    else begin
      errors++;
      $display("ERR %s %s expected %0h actual %0h", cur_test, what, expected, actual);
    end
  endtask

  task automatic csr_access(input logic we, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic err, output logic [31:0] rdata);
    int waited;
    csr_req.valid     = 1'b1;
    csr_req.we        = we;
    csr_req.addr      = addr;
    csr_req.wdata.raw = wdata;
    @(negedge clk);
    csr_req = '0;
    waited  = 0;
    while (!csr_rsp.valid && (waited < 4)) begin
      @(negedge clk);
      waited++;
    end
    if (!csr_rsp.valid) begin
      errors++;
      $display("No register response for address %0h", addr);
    end
    err   = csr_rsp.err;
    rdata = csr_rsp.rdata;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    logic        err;
    logic [31:0] rdata;
    csr_access(1'b1, addr, data, err, rdata);
    check_eq("write err", 1'b0, err);
    check_eq("write rdata", 32'h0, rdata);
  endtask

  task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
    logic err;
    csr_access(1'b0, addr, 32'h0, err, data);
    check_eq("read err", 1'b0, err);
  endtask

  task automatic configure_counter(input int idx, input logic irq_en, input logic [4:0] sel);
    write_reg(8'(EvtCfgBase + idx), {26'h0, irq_en, sel});
    sel_m[idx] = sel;
  endtask

  task automatic drive_cycle(input logic beat, input commit_rec_t rec, input hw_events_t hw,
                             input logic counting);
    commit_valid = beat;
    commit_rec   = rec;
    hw_events    = hw;
    if (counting) begin
      for (int i = 0; i < NumCounters; i++) begin
        if (!inhibit_m[i] && model_hit(sel_m[i], beat, rec, hw)) model[i] = model[i] + 64'd1;
      end
    end
    @(negedge clk);
    commit_valid = 1'b0;
    hw_events    = '0;
  endtask

  task automatic wait_drained();
    while (credits != int'(FifoDepth)) @(negedge clk);
    repeat (3) @(negedge clk);  // Decoder and counter stages
  endtask

  task automatic check_counters();
    logic [31:0] lo;
    logic [31:0] hi;
    for (int i = 0; i < NumCounters; i++) begin
      read_reg(8'(CntLoBase + i), lo);
      read_reg(8'(CntHiBase + i), hi);
      check_eq($sformatf("counter %0d", i), model[i], {hi, lo});
    end
  endtask

  initial begin
    logic        err;
    logic [31:0] rd;
    logic [31:0] w;
    rst_n        = 1'b0;
    commit_valid = 1'b0;
    commit_rec   = '0;
    hw_events    = '0;
    debug        = 1'b0;
    csr_req      = '0;
    inhibit_m    = '0;
    void'($urandom(32'h8322ee74));
    for (int i = 0; i < NumCounters; i++) begin
      model[i] = '0;
      sel_m[i] = '0;
    end
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    start_test("credits");
    check_eq("initial credits", FifoDepth, credits);
    for (int n = 0; n < 3 * FifoDepth; n++) begin
      if (credits > 0) drive_cycle(1'b1, random_rec(), '0, 1'b1);
      else @(negedge clk);
    end
    wait_drained();
    check_eq("credit pulses", beats_sent, pulses_seen);
    check_eq("final credits", FifoDepth, credits);
    end_test();

    start_test("register access");
    for (int i = 0; i < NumCounters; i++) begin
      w = {26'h3ff_ffff, 1'(i % 2), 5'(i + 8)};  // Reserved bits all set
      write_reg(8'(EvtCfgBase + i), w);
      read_reg(8'(EvtCfgBase + i), rd);
      check_eq("config readback", {26'h0, w[5:0]}, rd);
    end
    write_reg(InhibitAddr, 32'hffff_ffe9);
    read_reg(InhibitAddr, rd);
    check_eq("inhibit readback", 32'h29, rd);
    foreach (BadAddr[k]) begin
      csr_access(1'b0, BadAddr[k], 32'h0, err, rd);
      check_eq("unmapped read err", 1'b1, err);
      check_eq("unmapped read data", 32'h0, rd);
      csr_access(1'b1, BadAddr[k], 32'hffff_ffff, err, rd);
      check_eq("unmapped write err", 1'b1, err);
    end
    read_reg(InhibitAddr, rd);
    check_eq("inhibit after unmapped writes", 32'h29, rd);
    write_reg(InhibitAddr, 32'h0);
    end_test();

    start_test("event counting");
    for (int i = 0; i < NumCounters; i++) configure_counter(i, 1'b0, 5'($urandom_range(15, 0)));
    inhibit_m = 6'b010010;
    write_reg(InhibitAddr, 32'(inhibit_m));
    for (int n = 0; n < TrafficCycles; n++) begin
      drive_cycle((credits > 0) && ($urandom_range(3, 0) != 0), random_rec(),
                  hw_events_t'(6'($urandom)), 1'b1);
    end
    wait_drained();
    check_counters();
    end_test();

    start_test("overflow");
    inhibit_m = '0;
    write_reg(InhibitAddr, 32'h0);
    // Counter 0 counts icache misses with irq and the rest count stalls
    for (int i = 0; i < NumCounters; i++) begin
      configure_counter(i, i == 0, (i == 0) ? 5'd1 : 5'd14);
    end
    write_reg(CntLoBase, 32'hffff_fffe);
    write_reg(CntHiBase, 32'hffff_ffff);
    model[0] = 64'hffff_ffff_ffff_fffe;
    repeat (2) drive_cycle(1'b0, '0, 6'b100000, 1'b1);
    while (!irq) @(negedge clk);
    read_reg(OvfStatAddr, rd);
    check_eq("overflow status", 32'h1, rd);
    repeat (PulseCycles) drive_cycle(1'b0, '0, 6'b000001, 1'b0);  // Nothing counts while frozen
    repeat (4) @(negedge clk);
    check_counters();
    write_reg(OvfStatAddr, 32'h1);
    while (irq) @(negedge clk);
    read_reg(OvfStatAddr, rd);
    check_eq("cleared status", 32'h0, rd);
    repeat (PulseCycles) drive_cycle(1'b0, '0, 6'b000001, 1'b1);
    repeat (4) @(negedge clk);
    check_counters();
    end_test();

    start_test("debug halt");
    debug = 1'b1;
    repeat (2) @(negedge clk);
    repeat (PulseCycles) drive_cycle(1'b0, '0, hw_events_t'(6'($urandom)), 1'b0);
    repeat (3) @(negedge clk);
    check_counters();
    debug = 1'b0;
    repeat (2) @(negedge clk);
    repeat (PulseCycles) drive_cycle(1'b0, '0, hw_events_t'(6'($urandom)), 1'b1);
    repeat (3) @(negedge clk);
    check_counters();
    end_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: pmu.f
common/pmu_pkg.sv
source/commit_fifo.sv
perf_counters/event_decoder.sv
perf_counters/hpm_counter_bank.sv
perf_counters/count_ctrl_fsm.sv
source/pmu_csr_regs.sv
source/pmu_top.sv
tests/pmu_clk_gen.sv
tests/pmu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the PMU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module pmu_tb -f pmu.f -o pmu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/pmu_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Result: PASSED" <<< "$sim_out"; then
  exit 0
fi
exit 1
